/* l2cache_config.svh */
`ifndef L2CACHE_CONFIG_SVH
`define L2CACHE_CONFIG_SVH

// Cache geometry
`define L2_SETS 8
// Fixed at two ways, replacement uses one LRU bit per set
`define L2_WAYS 2

// Index and tag widths follow from the set count, one word per block
`define L2_IDX_BITS ($clog2(`L2_SETS))
`define L2_TAG_BITS (30 - `L2_IDX_BITS)

// Request queue entries, also the credits a requester starts with
`define L2_QUEUE_DEPTH 4

// Backing memory
`define L2_MEM_WORDS 256
`define L2_MEM_LATENCY 3 // Read issue to read data valid

`endif

/* l2CachePkg.sv */
package l2CachePkg;

    `include "l2cache_config.svh"

    typedef logic [31:0] addrT; // Byte address
    typedef logic [31:0] dataT;
    typedef logic [29:0] wordAddrT; // Byte address without the low two bits
    typedef logic [`L2_TAG_BITS-1:0] tagT;
    typedef logic [`L2_IDX_BITS-1:0] setIdxT;
    typedef logic [$clog2(`L2_WAYS)-1:0] wayT;
    typedef logic [2:0] sizeT; // funct3, 000 byte, 001 half, 010 word

    typedef struct packed {
        logic write;
        addrT addr;
        dataT data;
        sizeT size;
    } l2ReqT;

    typedef struct packed {
        dataT data; // Word after any store merge
        logic hit;
        logic write;
    } l2RespT;

    typedef struct packed {
        l2ReqT req;
        logic hit;
        wayT way; // Hit way, or the victim way on a miss
        logic evict; // Victim valid and dirty
        addrT victimAddr;
    } lookupT;

    typedef struct packed {
        logic write;
        wordAddrT wordAddr;
        dataT data;
    } memReqT;

    typedef enum logic [1:0] {
        idle,
        writeBack,
        refillWait,
        complete
    } dataStateT;

endpackage

/* l2ReqQueue.sv */
`include "l2cache_config.svh"

module l2ReqQueue
    import l2CachePkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  reqValid,
    input  l2ReqT req,
    input  logic  qReady,
    output logic  credit,
    output logic  qValid,
    output l2ReqT qReq
);

    localparam int depth = `L2_QUEUE_DEPTH;
    localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntBits = $clog2(depth + 1);

    l2ReqT entries [depth];
    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits-1:0] rdPtr;
    logic [cntBits-1:0] count;
    logic deq;

    assign qValid = (count != '0);
    assign qReq = entries[rdPtr];
    assign deq = qValid && qReady;

    // Requester never sends without a credit, so no full check here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            credit <= 1'b0;
        end else begin
            credit <= deq; // One credit back per entry handed on
            if (reqValid) begin
                wrPtr <= (wrPtr == ptrBits'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (deq) begin
                rdPtr <= (rdPtr == ptrBits'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({reqValid, deq})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            entries[wrPtr] <= req;
        end
    end

endmodule

/* l2TagLookup.sv */
`include "l2cache_config.svh"

module l2TagLookup
    import l2CachePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   qValid,
    input  l2ReqT  qReq,
    input  logic   dataBusy,
    output logic   qReady,
    output logic   luValid,
    output lookupT lu
);

    localparam int sets = `L2_SETS;
    localparam int ways = `L2_WAYS;

    tagT tagArr [sets][ways];
    logic [ways-1:0] validArr [sets];
    logic [ways-1:0] dirtyArr [sets];
    wayT lruArr [sets]; // Way to replace next

    tagT reqTag;
    setIdxT reqSet;
    logic hit0;
    logic hit1;
    logic hit;
    wayT victim;
    wayT selWay;
    logic evict;
    addrT victimAddr;
    logic take;

    assign reqTag = qReq.addr[31:`L2_IDX_BITS+2];
    assign reqSet = qReq.addr[`L2_IDX_BITS+1:2];

    // Compare both ways of the indexed set
    assign hit0 = validArr[reqSet][0] && (tagArr[reqSet][0] == reqTag);
    assign hit1 = validArr[reqSet][1] && (tagArr[reqSet][1] == reqTag);
    assign hit = hit0 || hit1;

    assign victim = lruArr[reqSet];
    assign selWay = hit ? wayT'(hit1) : victim;
    assign evict = !hit && validArr[reqSet][victim] && dirtyArr[reqSet][victim];
    assign victimAddr = {tagArr[reqSet][victim], reqSet, 2'b00};

    // Stall while the data stage services a miss
    assign qReady = !dataBusy;
    assign take = qValid && qReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            luValid <= 1'b0;
            for (int s = 0; s < sets; s++) begin
                validArr[s] <= '0;
                dirtyArr[s] <= '0;
                lruArr[s] <= '0;
            end
        end else begin
            if (!dataBusy) begin
                luValid <= qValid; // Held otherwise
            end
            if (take) begin
                lruArr[reqSet] <= ~selWay; // Point away from the used way
                if (hit) begin
                    if (qReq.write) begin
                        dirtyArr[reqSet][selWay] <= 1'b1;
                    end
                end else begin
                    validArr[reqSet][selWay] <= 1'b1;
                    dirtyArr[reqSet][selWay] <= qReq.write; // Loads install clean
                end
            end
        end
    end

    // Tag install and lookup result
    always_ff @(posedge clk) begin
        if (take) begin
            if (!hit) begin
                tagArr[reqSet][selWay] <= reqTag;
            end
            lu.req <= qReq;
            lu.hit <= hit;
            lu.way <= selWay;
            lu.evict <= evict;
            lu.victimAddr <= victimAddr;
        end
    end

endmodule

/* l2DataStage.sv */
`include "l2cache_config.svh"

module l2DataStage
    import l2CachePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   luValid,
    input  lookupT lu,
    input  logic   memRdValid,
    input  dataT   memRdData,
    output logic   dataBusy,
    output logic   memReqValid,
    output memReqT memReq,
    output logic   respValid,
    output l2RespT resp
);

    localparam int sets = `L2_SETS;
    localparam int ways = `L2_WAYS;

    dataT dataArr [sets][ways];
    dataStateT state;
    lookupT cur; // Miss being serviced

    setIdxT luSet;
    setIdxT curSet;
    dataT hitWord;
    dataT fillWord;

    // Store merge by funct3 and the low address bits
    function automatic dataT mergeStore(dataT old, l2ReqT r);
        dataT w;
        w = old;
        if (r.write) begin
            case (r.size[1:0])
                2'b00: w[8*r.addr[1:0] +: 8] = r.data[7:0]; // sb
                2'b01: w[16*r.addr[1] +: 16] = r.data[15:0]; // sh
                default: w = r.data;
            endcase
        end
        return w;
    endfunction

    assign luSet = lu.req.addr[`L2_IDX_BITS+1:2];
    assign curSet = cur.req.addr[`L2_IDX_BITS+1:2];
    assign hitWord = mergeStore(dataArr[luSet][lu.way], lu.req);
    assign fillWord = mergeStore(memRdData, cur.req);

    assign dataBusy = (state != idle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
            respValid <= 1'b0;
            memReqValid <= 1'b0;
        end else begin
            respValid <= 1'b0;
            memReqValid <= 1'b0;
            case (state)
                idle: begin
                    if (luValid) begin
                        if (lu.hit) begin
                            respValid <= 1'b1;
                        end else begin
                            memReqValid <= 1'b1; // Victim write or refill read
                            state <= lu.evict ? writeBack : refillWait;
                        end
                    end
                end
                writeBack: begin
                    memReqValid <= 1'b1; // Refill read follows the write
                    state <= refillWait;
                end
                refillWait: begin
                    if (memRdValid) begin
                        respValid <= 1'b1;
                        state <= complete;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (luValid) begin
                    cur <= lu;
                    if (lu.hit) begin
                        if (lu.req.write) begin
                            dataArr[luSet][lu.way] <= hitWord;
                        end
                        resp.data <= hitWord;
                        resp.hit <= 1'b1;
                        resp.write <= lu.req.write;
                    end else if (lu.evict) begin
                        memReq.write <= 1'b1;
                        memReq.wordAddr <= lu.victimAddr[31:2];
                        memReq.data <= dataArr[luSet][lu.way];
                    end else begin
                        memReq.write <= 1'b0;
                        memReq.wordAddr <= lu.req.addr[31:2];
                        memReq.data <= lu.req.data;
                    end
                end
            end
            writeBack: begin
                memReq.write <= 1'b0;
                memReq.wordAddr <= cur.req.addr[31:2];
                memReq.data <= cur.req.data;
            end
            refillWait: begin
                if (memRdValid) begin
                    dataArr[curSet][cur.way] <= fillWord; // Store merged into refill
                    resp.data <= fillWord;
                    resp.hit <= 1'b0;
                    resp.write <= cur.req.write;
                end
            end
            default: ;
        endcase
    end

endmodule

/* mainMemory.sv */
`include "l2cache_config.svh"

module mainMemory
    import l2CachePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   memReqValid,
    input  memReqT memReq,
    output logic   memRdValid,
    output dataT   memRdData
);

    localparam int lat = `L2_MEM_LATENCY;
    localparam int idxBits = $clog2(`L2_MEM_WORDS);

    dataT words [`L2_MEM_WORDS];
    logic [lat-1:0] validPipe;
    dataT dataPipe [lat];
    logic [idxBits-1:0] memIdx;

    assign memIdx = memReq.wordAddr[idxBits-1:0]; // Wraps above memory size

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `L2_MEM_WORDS; i++) begin
                words[i] <= '0;
            end
            validPipe <= '0;
        end else begin
            if (memReqValid && memReq.write) begin
                words[memIdx] <= memReq.data; // Write lands at the request edge
            end
            validPipe[0] <= memReqValid && !memReq.write;
            for (int i = 1; i < lat; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    // Read data travels alongside the valid bits
    always_ff @(posedge clk) begin
        dataPipe[0] <= words[memIdx];
        for (int i = 1; i < lat; i++) begin
            dataPipe[i] <= dataPipe[i-1];
        end
    end

    assign memRdValid = validPipe[lat-1];
    assign memRdData = dataPipe[lat-1];

endmodule

/* l2CacheTop.sv */
module l2CacheTop
    import l2CachePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   reqValid,
    input  l2ReqT  req,
    output logic   credit,
    output logic   respValid,
    output l2RespT resp
);

    logic qValid;
    logic qReady;
    l2ReqT qReq;
    logic luValid;
    lookupT lu;
    logic dataBusy;
    logic memReqValid;
    memReqT memReq;
    logic memRdValid;
    dataT memRdData;

    l2ReqQueue queue (
        .clk, .rst, .reqValid, .req, .qReady,
        .credit, .qValid, .qReq
    );

    l2TagLookup lookup (
        .clk, .rst, .qValid, .qReq, .dataBusy,
        .qReady, .luValid, .lu
    );

    l2DataStage dataStage (
        .clk, .rst, .luValid, .lu, .memRdValid, .memRdData,
        .dataBusy, .memReqValid, .memReq, .respValid, .resp
    );

    // Flat backing store behind the cache
    mainMemory memory (
        .clk, .rst, .memReqValid, .memReq,
        .memRdValid, .memRdData
    );

endmodule

/* l2cache_props.sv */
`include "l2cache_config.svh"

module l2CacheProps
    import l2CachePkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   reqValid,
    input logic   credit,
    input logic   respValid,
    input logic   memReqValid,
    input memReqT memReq,
    input logic   memRdValid
);

    int outstanding; // Requests sent and not yet credited back
    int failCount = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(reqValid) - int'(credit);
        end
    end

    creditLimit: assert property (@(posedge clk) disable iff (rst)
        outstanding >= 0 && outstanding <= `L2_QUEUE_DEPTH)
        else begin
            $error("outstanding requests %0d beyond the credit limit", outstanding);
            failCount++;
        end

    quietInReset: assert property (@(posedge clk) rst |-> !respValid)
        else begin
            $error("respValid high during reset");
            failCount++;
        end

    // Read data comes back a fixed number of cycles after the request
    readLatency: assert property (@(posedge clk) disable iff (rst)
        memReqValid && !memReq.write |-> ##(`L2_MEM_LATENCY) memRdValid)
        else begin
            $error("memory read data late or missing");
            failCount++;
        end

endmodule

bind l2CacheTop l2CacheProps props (
    .clk, .rst, .reqValid, .credit, .respValid, .memReqValid, .memReq, .memRdValid
);

/* l2cache_tb.sv */
`include "l2cache_config.svh"

module l2cache_tb
    import l2CachePkg::*;
();

    localparam sizeT sizeByte = 3'b000;
    localparam sizeT sizeHalf = 3'b001;
    localparam sizeT sizeWord = 3'b010;
    localparam int stepTimeout = 300; // Cycles allowed for any single wait

    logic clk = 1'b0;
    logic rst;
    logic reqValid;
    l2ReqT req;
    logic credit;
    logic respValid;
    l2RespT resp;

    int cycleCnt = 0;
    int credits;
    int issued = 0;
    int respCount = 0;
    int dataErrors = 0;
    int hitErrors = 0;
    int otherErrors = 0;
    int timeouts = 0;
    int acceptEdge;
    int respEdge;
    logic [31:0] lfsr = 32'he22d_8ba8;

    bit [31:0] refMem [`L2_MEM_WORDS]; // Flat memory image
    int refTag [`L2_SETS][2];
    bit refValid [`L2_SETS][2];
    bit refLru [`L2_SETS]; // Way to replace next
    l2RespT expected [$];

    l2CacheTop dut (
        .clk, .rst, .reqValid, .req, .credit, .respValid, .resp
    );

    always #20 clk = ~clk;
    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    function automatic logic [31:0] takeBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1); // Galois step
        end
        return v;
    endfunction

    function automatic l2ReqT makeReq(logic write, addrT addr, sizeT size, dataT data);
        l2ReqT r;
        r.write = write;
        r.addr = addr;
        r.size = size;
        r.data = data;
        return r;
    endfunction

    // Aligned access, 16 tags for every set
    function automatic l2ReqT randomReq();
        logic [31:0] sel;
        logic [1:0] off;
        sizeT size;
        sel = takeBits(12);
        size = (sel[1:0] == 2'b11) ? sizeWord : {1'b0, sel[1:0]};
        off = (size == sizeByte) ? sel[3:2] : (size == sizeHalf) ? {sel[2], 1'b0} : 2'b00;
        return makeReq(sel[11], {23'b0, sel[10:4], off}, size, takeBits(32));
    endfunction

    // Flat memory with byte lanes, plus a two-way tag model with one LRU bit
    function automatic l2RespT predict(l2ReqT r);
        l2RespT p;
        int set;
        int tag;
        int way;
        int idx;
        logic [31:0] mask;
        logic [31:0] lanes;
        set = (r.addr / 4) % `L2_SETS;
        tag = r.addr / (4 * `L2_SETS);
        idx = (r.addr / 4) % `L2_MEM_WORDS;
        p.hit = 1'b0;
        way = refLru[set];
        for (int w = 0; w < 2; w++) begin
            if (refValid[set][w] && refTag[set][w] == tag) begin
                p.hit = 1'b1;
                way = w;
            end
        end
        refTag[set][way] = tag;
        refValid[set][way] = 1'b1;
        refLru[set] = (way == 0);
        case (r.size)
            sizeByte: begin
                mask = 32'hff << (8 * r.addr[1:0]);
                lanes = {4{r.data[7:0]}};
            end
            sizeHalf: begin
                mask = 32'hffff << (8 * r.addr[1:0]);
                lanes = {2{r.data[15:0]}};
            end
            default: begin
                mask = 32'hffff_ffff;
                lanes = r.data;
            end
        endcase
        if (r.write) begin
            refMem[idx] = (refMem[idx] & ~mask) | (lanes & mask);
        end
        p.data = refMem[idx];
        p.write = r.write;
        return p;
    endfunction

    task automatic sendReq(input l2ReqT r);
        int waited;
        waited = 0;
        while (credits == 0 && waited < stepTimeout) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (credits == 0) begin
            $display("Timeout: no credit came back from the queue");
            timeouts++;
        end else begin
            reqValid = 1'b1;
            req = r;
            credits--;
            issued++;
            acceptEdge = cycleCnt + 1;
            expected.push_back(predict(r));
            @(posedge clk);
            #2;
            reqValid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expected.size() != 0 && waited < stepTimeout) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (expected.size() != 0) begin
            $display("Timeout: %0d responses never arrived", expected.size());
            timeouts++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && credit) begin
            credits++;
            if (credits > `L2_QUEUE_DEPTH) begin
                $display("Credit returned with no request outstanding");
                otherErrors++;
            end
        end
    end

    always @(negedge clk) begin
        l2RespT want;
        if (!rst && respValid) begin
            respCount++;
            respEdge = cycleCnt + 1; // Edge that samples this response
            if (expected.size() == 0) begin
                $display("Response arrived with no request outstanding");
                otherErrors++;
            end else begin
                want = expected.pop_front();
                if (resp.data !== want.data) begin
                    $display("Error: resp.data 0x%h expected 0x%h", resp.data, want.data);
                    dataErrors++;
                end
                if (resp.hit !== want.hit) begin
                    $display("Error: resp.hit 0x%h expected 0x%h", resp.hit, want.hit);
                    hitErrors++;
                end
                if (resp.write !== want.write) begin
                    $display("Error: resp.write 0x%h expected 0x%h", resp.write, want.write);
                    otherErrors++;
                end
            end
        end
    end

    task automatic reportAndFinish();
        int fails;
        fails = dataErrors + hitErrors + otherErrors + timeouts + dut.props.failCount;
        $display("Counts: req %0d resp %0d data %0d hit %0d other %0d timeout %0d assert %0d",
            issued, respCount, dataErrors, hitErrors, otherErrors, timeouts,
            dut.props.failCount);
        if (fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        rst = 1'b1;
        reqValid = 1'b0;
        req = '0;
        credits = `L2_QUEUE_DEPTH;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // Clean cache reads zero, first as a miss and then as a hit
        sendReq(makeReq(1'b0, 32'h0000_0040, sizeWord, '0));
        sendReq(makeReq(1'b0, 32'h0000_0040, sizeWord, '0));
        for (int off = 0; off < 4; off++) begin
            sendReq(makeReq(1'b1, 32'h0000_0024 + off, sizeByte, 32'h5a + off));
            sendReq(makeReq(1'b0, 32'h0000_0024, sizeWord, '0));
        end
        sendReq(makeReq(1'b1, 32'h0000_0088, sizeHalf, 32'h1234_beef));
        sendReq(makeReq(1'b1, 32'h0000_008a, sizeHalf, 32'h5678_cafe));
        sendReq(makeReq(1'b1, 32'h0000_008b, sizeByte, 32'h0000_0077));
        sendReq(makeReq(1'b0, 32'h0000_0088, sizeWord, '0));

        // Three tags in set 5, the third evicts the dirty first one
        sendReq(makeReq(1'b1, 32'h0000_0034, sizeWord, 32'h1111_aaaa));
        sendReq(makeReq(1'b1, 32'h0000_0054, sizeWord, 32'h2222_bbbb));
        sendReq(makeReq(1'b1, 32'h0000_0074, sizeWord, 32'h3333_cccc));
        sendReq(makeReq(1'b0, 32'h0000_0034, sizeWord, '0));
        drain();

        // Hit into an idle pipeline
        sendReq(makeReq(1'b0, 32'h0000_0034, sizeWord, '0));
        drain();
        if (respEdge - acceptEdge != 3) begin
            $display("Error: respValid latency 0x%h expected 0x%h", respEdge - acceptEdge, 3);
            otherErrors++;
        end

        for (int n = 0; n < 450; n++) begin
            sendReq(randomReq()); // Back to back while credits last
        end
        drain();
        if (respCount != issued) begin
            $display("Error: respCount 0x%h expected 0x%h", respCount, issued);
            otherErrors++;
        end
        reportAndFinish();
    end

endmodule

/* l2cache.f */
+incdir+.
l2CachePkg.sv
l2ReqQueue.sv
l2TagLookup.sv
l2DataStage.sv
mainMemory.sv
l2CacheTop.sv
l2cache_props.sv
l2cache_tb.sv
